/* list.f */
source/proc_pkg.sv
source/mem_if.sv
source/mem_arbiter.sv
source/fetch_unit.sv
source/decode_stage.sv
source/exec_stages.sv
source/proc_top.sv
verification/proc_assert.sv
verification/proc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the proc_tb simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module proc_tb -f list.f -o proc_tb_sim
./obj_dir/proc_tb_sim

/* verification/proc_tb.sv */
// -------------------------------------------------
// Testbench for proc_top: clock, reset, memory model,
// reference interpreter, output compare and watchdog
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module proc_tb;

  localparam logic [31:0] reset_pc  = 32'h0000_0080;
  localparam logic [5:0]  opc_bne   = 6'd5;
  localparam logic [5:0]  opc_addiu = 6'd9;
  localparam logic [5:0]  opc_mtc0  = 6'd16;
  localparam logic [5:0]  opc_lw    = 6'd35;
  localparam logic [5:0]  opc_sw    = 6'd43;

  logic        clk;
  logic        reset;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic [31:0] mem_req_addr;
  logic        mem_req_wen;
  logic [31:0] mem_req_wdata;
  logic        mem_resp_valid;
  logic [31:0] mem_resp_data;
  logic        to_mngr_valid;
  logic        to_mngr_ready;
  logic [31:0] to_mngr_data;

  logic [31:0] mem     [1024];  // Word memory seen by the DUT
  logic [31:0] ref_mem [1024];  // Private copy for the interpreter
  logic [31:0] expected_q [$];
  logic [31:0] lfsr;
  logic [9:0]  load_at;
  int          expected_steps = 0;
  int          expected_total = 0;
  int          outputs_seen   = 0;

  proc_top #(
    .reset_pc (reset_pc)
  ) u_proc_top (
    .clk            (clk),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wen    (mem_req_wen),
    .mem_req_wdata  (mem_req_wdata),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .to_mngr_valid  (to_mngr_valid),
    .to_mngr_ready  (to_mngr_ready),
    .to_mngr_data   (to_mngr_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------
  // Random bits, failure reporting, compare
  // ------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
      report_failure($sformatf("%s is %h, expected %h", what, actual, expected));
  endtask

  // ------------------------------------------------
  // Program encoding and reference interpreter
  // ------------------------------------------------
  function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] enc_addu(input int rd, input int rs, input int rt);
    return {6'd0, rs[4:0], rt[4:0], rd[4:0], 5'd0, 6'd33};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[load_at] = word;
    load_at = load_at + 10'd1;
  endtask

  // Runs ref_mem from reset_pc, returns the number of executed steps
  function automatic int run_reference();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    int          steps;
    regs  = '{default: '0};
    pc    = reset_pc;
    steps = 0;
    while (steps < 4000) begin
      ir      = ref_mem[pc[11:2]];
      rs      = ir[25:21];
      rt      = ir[20:16];
      rd      = ir[15:11];
      imm     = {{16{ir[15]}}, ir[15:0]};
      addr    = regs[rs] + imm;
      next_pc = pc + 32'd4;
      steps++;
      case (ir[31:26])
        6'd0:      if (ir[5:0] == 6'd33) regs[rd] = regs[rs] + regs[rt];
        opc_addiu: regs[rt] = regs[rs] + imm;
        opc_lw:    regs[rt] = ref_mem[addr[11:2]];
        opc_sw:    ref_mem[addr[11:2]] = regs[rt];
        opc_mtc0:  expected_q.push_back(regs[rt]);
        opc_bne: begin
          if (regs[rs] != regs[rt]) begin
            next_pc = pc + 32'd4 + {imm[29:0], 2'b00};
            if (next_pc == pc) return steps;  // Branch to itself ends the program
          end
        end
        default: ;
      endcase
      regs[0] = '0;
      pc = next_pc;
    end
    return steps;
  endfunction

  task automatic load_program();
    for (int i = 0; i < 1024; i++) mem[i[9:0]] = 32'hfc00_0000 | i;  // Unused opcode 63
    load_at = reset_pc[11:2];
    // Back-to-back dependent adds, then a write to r0
    emit(enc_i(opc_addiu, 0, 1, 5));
    emit(enc_i(opc_addiu, 1, 2, 7));
    emit(enc_addu(3, 1, 2));
    emit(enc_addu(4, 3, 3));
    emit(enc_i(opc_addiu, 4, 0, 9));
    emit(enc_addu(5, 0, 4));
    emit(enc_i(opc_mtc0, 4, 3, 0));
    emit(enc_i(opc_mtc0, 4, 4, 0));
    emit(enc_i(opc_mtc0, 4, 5, 0));
    // Store then load, result used right away
    emit(enc_i(opc_addiu, 0, 6, 32'h200));
    emit(enc_i(opc_sw, 6, 4, 0));
    emit(enc_i(opc_lw, 6, 7, 0));
    emit(enc_addu(8, 7, 1));
    emit(enc_i(opc_mtc0, 4, 8, 0));
    emit(enc_i(opc_addiu, 0, 9, -3));
    emit(enc_i(opc_sw, 6, 9, 4));
    emit(enc_i(opc_lw, 6, 10, 4));
    emit(enc_i(opc_mtc0, 4, 10, 0));
    // Countdown loop, the MTC0 behind the BNE only runs on fall-through
    emit(enc_i(opc_addiu, 0, 11, 4));
    emit(enc_i(opc_addiu, 11, 11, -1));
    emit(enc_i(opc_mtc0, 4, 11, 0));
    emit(enc_i(opc_bne, 11, 0, -3));
    emit(enc_i(opc_mtc0, 4, 1, 0));
    emit(enc_i(opc_addiu, 0, 12, 77));
    emit(enc_i(opc_mtc0, 4, 12, 0));
    emit(enc_i(opc_bne, 1, 0, -1));  // Halt
  endtask

  // ------------------------------------------------
  // Memory model and to_mngr ready
  // ------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] resp_word;
    int          resp_wait;
    logic        first_req;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    to_mngr_ready  = 1'b0;
    lfsr           = 32'h6796_3884;
    resp_word      = '0;
    resp_wait      = 0;
    first_req      = 1'b1;
    @(negedge reset);
    forever begin
      @(negedge clk);
      mem_resp_valid = 1'b0;
      if (resp_wait != 0) begin
        resp_wait = resp_wait - 1;
        if (resp_wait == 0) begin
          mem_resp_valid = 1'b1;
          mem_resp_data  = resp_word;
        end
      end
      take_bits(1, r);
      mem_req_ready = r[0];
      take_bits(1, r);
      to_mngr_ready = r[0];
      if (mem_req_valid) begin
        if (first_req) check_equal(mem_req_addr, reset_pc, "first fetch address");
        first_req = 1'b0;
        if (mem_req_ready) begin
          take_bits(2, r);
          resp_wait = 1 + r % 3;  // Answer 1 to 3 cycles later
          resp_word = mem[mem_req_addr[11:2]];
          if (mem_req_wen) begin
            mem[mem_req_addr[11:2]] = mem_req_wdata;
            resp_word = '0;
          end
        end
      end
    end
  end

  // Output compare, sampled at the edge where the handshake happens
  initial begin
    forever begin
      @(posedge clk);
      if (!reset && to_mngr_valid && to_mngr_ready) begin
        if (expected_q.size() == 0)
          report_failure($sformatf("extra to_mngr output %h", to_mngr_data));
        else
          check_equal(to_mngr_data, expected_q.pop_front(), "to_mngr_data");
        outputs_seen++;
      end
    end
  end

  initial begin
    wait (expected_steps != 0);
    repeat (expected_steps * 40 + 210) @(posedge clk);
    $display("Watchdog timeout: the pipeline did not deliver all outputs in time");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset = 1'b1;
    load_program();
    ref_mem        = mem;
    expected_steps = run_reference();
    expected_total = expected_q.size();
    repeat (10) begin
      @(negedge clk);
      check_equal(32'(mem_req_valid), 32'd0, "mem_req_valid in reset");
      check_equal(32'(to_mngr_valid), 32'd0, "to_mngr_valid in reset");
    end
    reset = 1'b0;
    wait (outputs_seen == expected_total);
    repeat (200) @(negedge clk);  // Nothing more may come out
    if (outputs_seen == expected_total && expected_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "output count mismatch");
    end
  end

endmodule

`default_nettype wire

/* verification/proc_assert.sv */
// -------------------------------------------------
// Bus handshake assertions, bound into mem_arbiter
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module proc_assert (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        mem_req_valid,
  input wire logic        mem_req_ready,
  input wire logic [31:0] mem_req_addr,
  input wire logic        mem_req_wen,
  input wire logic [31:0] mem_req_wdata,
  input wire logic        mem_resp_valid
);

  bit   reset_seen;  // Reset was high at the previous edge
  logic in_flight;

  always_ff @(posedge clk) reset_seen <= reset;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      in_flight <= 1'b1;
    end else if (mem_resp_valid) begin
      in_flight <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
    $stable(mem_req_wen) && $stable(mem_req_wdata))
    else $error("memory request changed before it was accepted");

  one_in_flight: assert property (@(posedge clk) disable iff (reset)
    in_flight |-> !(mem_req_valid && mem_req_ready))
    else $error("second grant while a response is outstanding");

  quiet_in_reset: assert property (@(posedge clk)
    reset && reset_seen |-> !mem_req_valid)
    else $error("memory request during reset");

endmodule

bind mem_arbiter proc_assert u_proc_assert (
  .clk            (clk),
  .reset          (reset),
  .mem_req_valid  (mem_req_valid),
  .mem_req_ready  (mem_req_ready),
  .mem_req_addr   (mem_req_addr),
  .mem_req_wen    (mem_req_wen),
  .mem_req_wdata  (mem_req_wdata),
  .mem_resp_valid (mem_resp_valid)
);

`default_nettype wire

/* source/proc_top.sv */
// -------------------------------------------------
// Processor top: fetch, decode, execute stages and
// the memory arbiter behind plain bus ports
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module proc_top #(
  parameter proc_pkg::word_t reset_pc = '0
) (
  input  wire logic       clk,
  input  wire logic       reset,
  output logic            mem_req_valid,
  input  wire logic       mem_req_ready,
  output proc_pkg::word_t mem_req_addr,
  output logic            mem_req_wen,
  output proc_pkg::word_t mem_req_wdata,
  input  wire logic       mem_resp_valid,
  input  proc_pkg::word_t mem_resp_data,
  output logic            to_mngr_valid,
  input  wire logic       to_mngr_ready,
  output proc_pkg::word_t to_mngr_data
);
  import proc_pkg::*;

  mem_if ifetch_bus ();
  mem_if data_bus ();

  logic       inst_valid;
  word_t      inst;
  word_t      pc_plus4;
  logic       stall_d;
  logic       stall_x;
  logic       redirect;
  word_t      redirect_pc;
  logic       dx_valid;
  dx_t        dx;
  stage_fwd_t fwd_x;
  stage_fwd_t fwd_m;
  logic       w_wen;
  reg_addr_t  w_addr;
  word_t      w_data;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk         (clk),
    .reset       (reset),
    .mem         (ifetch_bus.requester),
    .stall_d     (stall_d),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc_plus4    (pc_plus4)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc_plus4   (pc_plus4),
    .squash     (redirect),  // Taken branch kills D
    .stall_x    (stall_x),
    .fwd_x      (fwd_x),
    .fwd_m      (fwd_m),
    .w_wen      (w_wen),
    .w_addr     (w_addr),
    .w_data     (w_data),
    .stall_d    (stall_d),
    .dx_valid   (dx_valid),
    .dx         (dx)
  );

  exec_stages u_exec (
    .clk           (clk),
    .reset         (reset),
    .dx_valid      (dx_valid),
    .dx            (dx),
    .mem           (data_bus.requester),
    .to_mngr_valid (to_mngr_valid),
    .to_mngr_ready (to_mngr_ready),
    .to_mngr_data  (to_mngr_data),
    .stall_x       (stall_x),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .fwd_x         (fwd_x),
    .fwd_m         (fwd_m),
    .w_wen         (w_wen),
    .w_addr        (w_addr),
    .w_data        (w_data)
  );

  mem_arbiter u_arbiter (
    .clk            (clk),
    .reset          (reset),
    .ifetch         (ifetch_bus.arbiter),
    .data           (data_bus.arbiter),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wen    (mem_req_wen),
    .mem_req_wdata  (mem_req_wdata),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data)
  );

endmodule

`default_nettype wire

/* source/exec_stages.sv */
// -------------------------------------------------
// X, M and W stages: adder, BNE resolution, data
// access, register write and the to_mngr output
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exec_stages (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            dx_valid,
  input  proc_pkg::dx_t        dx,
  mem_if.requester             mem,
  output logic                 to_mngr_valid,
  input  wire logic            to_mngr_ready,
  output proc_pkg::word_t      to_mngr_data,
  output logic                 stall_x,
  output logic                 redirect,
  output proc_pkg::word_t      redirect_pc,
  output proc_pkg::stage_fwd_t fwd_x,
  output proc_pkg::stage_fwd_t fwd_m,
  output logic                 w_wen,
  output proc_pkg::reg_addr_t  w_addr,
  output proc_pkg::word_t      w_data
);
  import proc_pkg::*;

  word_t      x_alu_b;
  word_t      x_result;
  logic       x_taken;

  logic       m_valid;
  inst_kind_e m_kind;
  word_t      m_result;      // Address or sum, then load data
  word_t      m_store_data;
  reg_addr_t  m_dest;
  logic       m_wen;
  logic       m_req_sent;
  logic       m_resp_done;
  logic       m_is_mem;
  logic       m_done;
  logic       stall_m;
  word_t      m_value;

  logic       wb_valid;
  inst_kind_e wb_kind;
  word_t      wb_value;
  reg_addr_t  wb_dest;
  logic       wb_wen;
  logic       w_hold;

  // ------------------------------------------------
  // X stage
  // ------------------------------------------------
  assign x_alu_b  = (dx.kind == k_addu) ? dx.op_b : dx.imm;
  assign x_result = (dx.kind == k_mtc0) ? dx.op_b : dx.op_a + x_alu_b;
  assign x_taken  = dx_valid && dx.kind == k_bne && dx.op_a != dx.op_b;

  assign redirect    = x_taken && !stall_x;  // Once, as the branch leaves X
  assign redirect_pc = dx.pc_plus4 + {dx.imm[xlen-3:0], 2'b00};

  always_comb begin
    fwd_x.valid   = dx_valid;
    fwd_x.is_load = dx.kind == k_lw;
    fwd_x.wen     = dx.wen;
    fwd_x.dest    = dx.dest;
    fwd_x.value   = x_result;
  end

  // ------------------------------------------------
  // M stage
  // ------------------------------------------------
  assign m_is_mem = m_kind == k_lw || m_kind == k_sw;

  assign mem.req_valid = m_valid && m_is_mem && !m_req_sent;
  assign mem.req_addr  = m_result;
  assign mem.req_wen   = m_kind == k_sw;
  assign mem.req_wdata = m_store_data;

  assign m_done  = !m_is_mem || m_resp_done || mem.resp_valid;
  assign stall_m = (m_valid && !m_done) || w_hold;
  assign stall_x = stall_m;
  assign m_value = (m_kind == k_lw && mem.resp_valid) ? mem.resp_data : m_result;

  always_comb begin
    fwd_m.valid   = m_valid;
    fwd_m.is_load = m_kind == k_lw;
    fwd_m.wen     = m_wen;
    fwd_m.dest    = m_dest;
    fwd_m.value   = m_value;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid     <= 1'b0;
      m_req_sent  <= 1'b0;
      m_resp_done <= 1'b0;
    end else if (!stall_m) begin
      m_valid     <= dx_valid;
      m_req_sent  <= 1'b0;
      m_resp_done <= 1'b0;
    end else begin
      if (mem.req_valid && mem.req_ready) m_req_sent <= 1'b1;
      if (mem.resp_valid) m_resp_done <= 1'b1;  // W may still be busy
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_m) begin
      m_kind       <= dx.kind;
      m_result     <= x_result;
      m_store_data <= dx.op_b;
      m_dest       <= dx.dest;
      m_wen        <= dx.wen;
    end else if (mem.resp_valid && m_kind == k_lw) begin
      m_result <= mem.resp_data;
    end
  end

  // ------------------------------------------------
  // W stage
  // ------------------------------------------------
  assign to_mngr_valid = wb_valid && wb_kind == k_mtc0;
  assign to_mngr_data  = wb_value;
  assign w_hold        = to_mngr_valid && !to_mngr_ready;

  assign w_wen  = wb_valid && wb_wen;
  assign w_addr = wb_dest;
  assign w_data = wb_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else if (!w_hold) begin
      wb_valid <= m_valid && m_done;  // Bubble while M waits
    end
  end

  always_ff @(posedge clk) begin
    if (!w_hold) begin
      wb_kind  <= m_kind;
      wb_value <= m_value;
      wb_dest  <= m_dest;
      wb_wen   <= m_wen;
    end
  end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// -------------------------------------------------
// Register file, decoder, bypass select and the
// load-use stall, ending in the D/X register
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            inst_valid,
  input  proc_pkg::word_t      inst,
  input  proc_pkg::word_t      pc_plus4,
  input  wire logic            squash,
  input  wire logic            stall_x,
  input  proc_pkg::stage_fwd_t fwd_x,
  input  proc_pkg::stage_fwd_t fwd_m,
  input  wire logic            w_wen,
  input  proc_pkg::reg_addr_t  w_addr,
  input  proc_pkg::word_t      w_data,
  output logic                 stall_d,
  output logic                 dx_valid,
  output proc_pkg::dx_t        dx
);
  import proc_pkg::*;

  word_t      rf [reg_count];
  opcode_e    opcode;
  reg_addr_t  rs;
  reg_addr_t  rt;
  reg_addr_t  rd;
  word_t      imm_sext;
  inst_kind_e dec_kind;
  logic       rs_en;
  logic       rt_en;
  logic       dec_wen;
  reg_addr_t  dec_dest;
  word_t      rs_data;
  word_t      rt_data;
  bypass_e    byp_a;
  bypass_e    byp_b;
  logic       load_use;
  dx_t        dx_next;

  // Newest writer wins, a load still in X cannot forward
  function automatic bypass_e sel_bypass(reg_addr_t src, logic en,
                                         stage_fwd_t fx, stage_fwd_t fm);
    if (!en || src == '0) return byp_none;
    if (fx.valid && fx.wen && fx.dest == src) return fx.is_load ? byp_none : byp_x;
    if (fm.valid && fm.wen && fm.dest == src) return byp_m;
    return byp_none;
  endfunction

  function automatic word_t bypass_value(bypass_e sel, word_t rf_val,
                                         stage_fwd_t fx, stage_fwd_t fm);
    case (sel)
      byp_x:   return fx.value;
      byp_m:   return fm.value;
      default: return rf_val;
    endcase
  endfunction

  // ------------------------------------------------
  // Decode
  // ------------------------------------------------
  assign opcode   = opcode_e'(inst[op_lsb +: 6]);
  assign rs       = inst[rs_lsb +: 5];
  assign rt       = inst[rt_lsb +: 5];
  assign rd       = inst[rd_lsb +: 5];
  assign imm_sext = {{(xlen - imm_msb - 1){inst[imm_msb]}}, inst[imm_msb:0]};

  always_comb begin
    dec_kind = k_nop;  // Anything unknown flows through harmlessly
    rs_en    = 1'b0;
    rt_en    = 1'b0;
    dec_wen  = 1'b0;
    dec_dest = rt;
    case (opcode)
      op_special: begin
        if (inst[5:0] == funct_addu) begin
          dec_kind = k_addu;
          rs_en    = 1'b1;
          rt_en    = 1'b1;
          dec_wen  = 1'b1;
          dec_dest = rd;
        end
      end
      op_addiu: begin
        dec_kind = k_addiu;
        rs_en    = 1'b1;
        dec_wen  = 1'b1;
      end
      op_lw: begin
        dec_kind = k_lw;
        rs_en    = 1'b1;
        dec_wen  = 1'b1;
      end
      op_sw: begin
        dec_kind = k_sw;
        rs_en    = 1'b1;
        rt_en    = 1'b1;  // Store data
      end
      op_bne: begin
        dec_kind = k_bne;
        rs_en    = 1'b1;
        rt_en    = 1'b1;
      end
      op_mtc0: begin
        dec_kind = k_mtc0;
        rt_en    = 1'b1;
      end
      default: ;
    endcase
  end

  // ------------------------------------------------
  // Operands and hazards
  // ------------------------------------------------
  // W writes this cycle, so read through it
  assign rs_data = (rs == '0) ? '0 : (w_wen && w_addr == rs) ? w_data : rf[rs];
  assign rt_data = (rt == '0) ? '0 : (w_wen && w_addr == rt) ? w_data : rf[rt];

  assign byp_a = sel_bypass(rs, rs_en, fwd_x, fwd_m);
  assign byp_b = sel_bypass(rt, rt_en, fwd_x, fwd_m);

  assign load_use = inst_valid && fwd_x.valid && fwd_x.is_load && fwd_x.dest != '0 &&
                    ((rs_en && rs == fwd_x.dest) || (rt_en && rt == fwd_x.dest));

  assign stall_d = stall_x || load_use;

  always_comb begin
    dx_next.kind     = dec_kind;
    dx_next.pc_plus4 = pc_plus4;
    dx_next.op_a     = bypass_value(byp_a, rs_data, fwd_x, fwd_m);
    dx_next.op_b     = bypass_value(byp_b, rt_data, fwd_x, fwd_m);
    dx_next.imm      = imm_sext;
    dx_next.dest     = dec_dest;
    dx_next.wen      = dec_wen;
  end

  // Bubble on load-use or squash, hold while X is stuck
  always_ff @(posedge clk) begin
    if (reset) begin
      dx_valid <= 1'b0;
    end else if (!stall_x) begin
      dx_valid <= inst_valid && !load_use && !squash;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_x) dx <= dx_next;
    if (w_wen && w_addr != '0) rf[w_addr] <= w_data;
  end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
// -------------------------------------------------
// PC, fetch requests, branch redirect and the
// one-entry skid buffer in front of decode
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
  parameter proc_pkg::word_t reset_pc = '0
) (
  input  wire logic       clk,
  input  wire logic       reset,
  mem_if.requester        mem,
  input  wire logic       stall_d,
  input  wire logic       redirect,
  input  proc_pkg::word_t redirect_pc,
  output logic            inst_valid,
  output proc_pkg::word_t inst,
  output proc_pkg::word_t pc_plus4
);
  import proc_pkg::*;

  word_t pc;           // Next fetch address
  word_t target;       // Redirect held behind a waiting request
  word_t buf_inst;
  logic  active;
  logic  outstanding;
  logic  drop;         // Next response is from the wrong path
  logic  retarget;
  logic  buf_valid;
  logic  req_fire;
  logic  req_pending;
  logic  resp_ok;

  // Next request waits for the previous word to leave
  assign mem.req_valid = active && !outstanding && !buf_valid;
  assign mem.req_addr  = pc;
  assign mem.req_wen   = 1'b0;
  assign mem.req_wdata = '0;

  assign req_fire    = mem.req_valid && mem.req_ready;
  assign req_pending = mem.req_valid && !mem.req_ready;
  assign resp_ok     = mem.resp_valid && !drop;

  assign inst_valid = buf_valid || resp_ok;
  assign inst       = buf_valid ? buf_inst : mem.resp_data;
  assign pc_plus4   = pc;  // pc already moved past the word in D

  always_ff @(posedge clk) begin
    if (reset) begin
      active      <= 1'b0;
      pc          <= reset_pc;
      outstanding <= 1'b0;
      drop        <= 1'b0;
      retarget    <= 1'b0;
      buf_valid   <= 1'b0;
    end else begin
      active <= 1'b1;

      if (req_fire) outstanding <= 1'b1;
      else if (mem.resp_valid) outstanding <= 1'b0;

      // A request already on its way cannot be taken back
      if (req_fire) begin
        if (redirect || retarget) drop <= 1'b1;
      end else if (redirect && outstanding && !mem.resp_valid) begin
        drop <= 1'b1;
      end else if (mem.resp_valid) begin
        drop <= 1'b0;
      end

      if (redirect && !req_pending) begin
        pc <= redirect_pc;
      end else if (req_fire) begin
        pc <= retarget ? target : pc + 32'd4;
      end

      if (redirect && req_pending) retarget <= 1'b1;
      else if (req_fire) retarget <= 1'b0;

      if (redirect) begin
        buf_valid <= 1'b0;
      end else if (resp_ok && stall_d) begin
        buf_valid <= 1'b1;
      end else if (!stall_d) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (redirect) target <= redirect_pc;
    if (resp_ok && stall_d) buf_inst <= mem.resp_data;
  end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
// -------------------------------------------------
// Two-way arbiter for the external memory bus
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
  input  wire logic          clk,
  input  wire logic          reset,
  mem_if.arbiter             ifetch,
  mem_if.arbiter             data,
  output logic               mem_req_valid,
  input  wire logic          mem_req_ready,
  output proc_pkg::word_t    mem_req_addr,
  output logic               mem_req_wen,
  output proc_pkg::word_t    mem_req_wdata,
  input  wire logic          mem_resp_valid,
  input  proc_pkg::word_t    mem_resp_data
);
  import proc_pkg::*;

  logic busy;        // One transaction in flight
  logic owner_data;  // Who gets the next response
  logic locked;      // Presented last cycle but not taken
  logic lock_data;
  logic sel_data;
  logic req_fire;

  // Data first, unless a fetch is already sitting on the bus
  assign sel_data = locked ? lock_data : data.req_valid;

  assign mem_req_valid = !busy && (sel_data ? data.req_valid : ifetch.req_valid);
  assign mem_req_addr  = sel_data ? data.req_addr  : ifetch.req_addr;
  assign mem_req_wen   = sel_data ? data.req_wen   : ifetch.req_wen;
  assign mem_req_wdata = sel_data ? data.req_wdata : ifetch.req_wdata;

  assign data.req_ready   = !busy && sel_data && mem_req_ready;
  assign ifetch.req_ready = !busy && !sel_data && mem_req_ready;

  assign req_fire = mem_req_valid && mem_req_ready;

  // Responses go only to the owner
  assign data.resp_valid   = mem_resp_valid && busy && owner_data;
  assign ifetch.resp_valid = mem_resp_valid && busy && !owner_data;
  assign data.resp_data    = mem_resp_data;
  assign ifetch.resp_data  = mem_resp_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      owner_data <= 1'b0;
      locked     <= 1'b0;
      lock_data  <= 1'b0;
    end else begin
      if (req_fire) begin
        busy       <= 1'b1;
        owner_data <= sel_data;
      end else if (mem_resp_valid) begin
        busy <= 1'b0;
      end
      locked    <= mem_req_valid && !mem_req_ready;  // Keep the bus stable
      lock_data <= sel_data;
    end
  end

endmodule

`default_nettype wire

/* source/mem_if.sv */
// -------------------------------------------------
// One requester's view of the shared memory bus
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface mem_if;
  import proc_pkg::*;

  logic  req_valid;
  logic  req_ready;
  word_t req_addr;   // Byte address
  logic  req_wen;
  word_t req_wdata;

  // No ready here, the owner takes it at once
  logic  resp_valid;
  word_t resp_data;

  modport requester (
    output req_valid, req_addr, req_wen, req_wdata,
    input  req_ready, resp_valid, resp_data
  );

  modport arbiter (
    input  req_valid, req_addr, req_wen, req_wdata,
    output req_ready, resp_valid, resp_data
  );

endinterface

`default_nettype wire

/* source/proc_pkg.sv */
// -------------------------------------------------
// Shared widths, instruction fields, enums and
// stage payload structs for the pipeline
// -------------------------------------------------
`default_nettype none

package proc_pkg;

  localparam int xlen      = 32;
  localparam int reg_count = 32;

  // Instruction field positions
  localparam int op_lsb  = 26;
  localparam int rs_lsb  = 21;
  localparam int rt_lsb  = 16;
  localparam int rd_lsb  = 11;
  localparam int imm_msb = 15;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  typedef enum logic [5:0] {
    op_special = 6'd0,
    op_bne     = 6'd5,
    op_addiu   = 6'd9,
    op_mtc0    = 6'd16,
    op_lw      = 6'd35,
    op_sw      = 6'd43
  } opcode_e;

  localparam logic [5:0] funct_addu = 6'd33;  // Low bits of a special inst

  typedef enum logic [2:0] {
    k_nop, k_addu, k_addiu, k_lw, k_sw, k_bne, k_mtc0
  } inst_kind_e;

  typedef enum logic [1:0] {
    byp_none,  // Register file
    byp_x,
    byp_m
  } bypass_e;

  // D to X payload
  typedef struct packed {
    inst_kind_e kind;
    word_t      pc_plus4;
    word_t      op_a;
    word_t      op_b;
    word_t      imm;       // Sign extended
    reg_addr_t  dest;
    logic       wen;
  } dx_t;

  // What a later stage tells D about itself
  typedef struct packed {
    logic      valid;
    logic      is_load;
    logic      wen;
    reg_addr_t dest;
    word_t     value;
  } stage_fwd_t;

endpackage

`default_nettype wire
